// ==== dv/outputPortPatterns.txt ====
// Columns in hex: cycle, input port (0 Local .. 4 South), type (1 header, 2 body, 4 tail),
// length, data. Headers per port: Local 3, North 2, East 4, West 1, South 0. ffff ends the list
0002 0 1 003 1100
0002 0 2 000 1101
0002 0 4 000 1102
0006 2 1 004 3100
0006 2 4 000 3101
000a 4 1 000 5100
000a 4 2 000 5101
000a 4 4 000 5102
000c 1 1 002 2100
000c 1 4 000 2101
000c 3 1 001 4100
000c 3 4 000 4101
0020 0 1 003 1200
0020 0 2 000 1201
0020 0 2 000 1202
0020 0 2 000 1203
0020 0 4 000 1204
0020 1 1 002 2200
0020 1 2 000 2201
0020 1 2 000 2202
0020 1 2 000 2203
0020 1 4 000 2204
0020 2 1 004 3200
0020 2 2 000 3201
0020 2 2 000 3202
0020 2 2 000 3203
0020 2 4 000 3204
0020 3 1 001 4200
0020 3 2 000 4201
0020 3 2 000 4202
0020 3 2 000 4203
0020 3 4 000 4204
0020 4 1 000 5200
0020 4 2 000 5201
0020 4 2 000 5202
0020 4 2 000 5203
0020 4 4 000 5204
ffff 0 0 000 0000

// ==== flist.f ====
design/routerPkg.sv
design/flitFifo.sv
design/grantTimer.sv
design/outputArbiter.sv
design/outputMux.sv
design/outputPort.sv
dv/outputPortChecker.sv
dv/outputPortTb.sv

// ==== Makefile ====
TOP = outputPortTb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/outputPortTb.sv ====
`timescale 1ns/10ps

module outputPortTb;

  localparam int maxLines = 64;
  localparam int lineWords = 5; // Cycle, port, type, length, data

  logic clk = 1'b0;
  logic rst;
  routerPkg::flit_t inFlit [routerPkg::numPorts];
  logic [routerPkg::numPorts-1:0] inValid;
  logic [routerPkg::numPorts-1:0] inReady;
  routerPkg::outFlit_t outFlit;
  logic outValid;
  logic outReady;

  logic [15:0] patMem [maxLines * lineWords];
  int nextLine [routerPkg::numPorts];
  int numLines;
  int lastCycle;
  int linesLeft;
  int cycle;
  int tbErrors;
  int checkErrors;
  int pendingFlits;
  int deliveredFlits;
  integer seed;
  logic holding;
  bit loaded = 1'b0;

  outputPort i_outputPort (
    .clk(clk),
    .rst(rst),
    .inFlit(inFlit),
    .inValid(inValid),
    .inReady(inReady),
    .outFlit(outFlit),
    .outValid(outValid),
    .outReady(outReady)
  );

  outputPortChecker i_outputPortChecker (
    .clk(clk),
    .rst(rst),
    .inFlit(inFlit),
    .inValid(inValid),
    .inReady(inReady),
    .outFlit(outFlit),
    .outValid(outValid),
    .outReady(outReady),
    .errorCount(checkErrors),
    .pendingFlits(pendingFlits),
    .deliveredFlits(deliveredFlits)
  );

  always #10 clk = ~clk;

  // Index of the next pattern line for a port, numLines when there is none
  function automatic int findLine(input int port, input int from);
    int line;
    line = from;
    while (line < numLines && int'(patMem[line * lineWords + 1]) != port)
      line++;
    return line;
  endfunction

  function automatic routerPkg::flit_t lineFlit(input int line);
    routerPkg::flit_t f;
    f.flitType = routerPkg::flitType_t'(patMem[line * lineWords + 2][2:0]);
    f.length = patMem[line * lineWords + 3][routerPkg::lengthWidth-1:0];
    f.data = patMem[line * lineWords + 4];
    return f;
  endfunction

  always @(posedge clk)
  begin
    if (!rst)
    begin
      cycle = cycle + 1;
      for (int p = 0; p < routerPkg::numPorts; p++)
      begin
        holding = inValid[p] && !inReady[p]; // Offered flit not taken yet
        if (inValid[p] && inReady[p])
          linesLeft = linesLeft - 1;
        if (!holding)
        begin
          if (nextLine[p] < numLines && int'(patMem[nextLine[p] * lineWords]) <= cycle)
          begin
            inFlit[p] <= lineFlit(nextLine[p]);
            inValid[p] <= 1'b1;
            nextLine[p] = findLine(p, nextLine[p] + 1);
          end
          else
            inValid[p] <= 1'b0;
        end
      end
      outReady <= ($random(seed) & 3) != 0; // Low about one cycle in four
    end
  end

  initial
  begin
    rst <= 1'b1;
    inValid <= '0;
    outReady <= 1'b0;
    for (int p = 0; p < routerPkg::numPorts; p++)
      inFlit[p] <= '0;
    seed = 32'h9b2cd549;
    cycle = 0;
    tbErrors = 0;
    $readmemh("dv/outputPortPatterns.txt", patMem);
    numLines = 0;
    lastCycle = 0;
    while (numLines < maxLines && patMem[numLines * lineWords] != 16'hffff)
    begin
      if (int'(patMem[numLines * lineWords]) > lastCycle)
        lastCycle = int'(patMem[numLines * lineWords]);
      numLines++;
    end
    for (int p = 0; p < routerPkg::numPorts; p++)
      nextLine[p] = findLine(p, 0);
    linesLeft = numLines;
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    do
      @(negedge clk);
    while (linesLeft > 0 || pendingFlits > 0);
    repeat (4) @(negedge clk); // A few idle cycles for the checker to see
    if (numLines == 0 || deliveredFlits != numLines)
    begin
      tbErrors++;
      $display("[ERROR] %0t ns: %0d flits delivered out of %0d pattern lines",
               $time, deliveredFlits, numLines);
    end
    $display("Errors: %0d from the checker, %0d from the testbench", checkErrors, tbErrors);
    if (checkErrors + tbErrors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Generous bound since every flit can be stalled and rotated many times
  initial
  begin
    wait (loaded);
    repeat (5 + 20 * lastCycle + 500) @(posedge clk);
    $display("Run timed out with %0d flits still undelivered", numLines - deliveredFlits);
    $display("Errors: %0d from the checker, %0d from the testbench", checkErrors, tbErrors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== dv/outputPortChecker.sv ====
`timescale 1ns/10ps

module outputPortChecker (
  input logic clk,
  input logic rst,
  input routerPkg::flit_t inFlit [routerPkg::numPorts],
  input logic [routerPkg::numPorts-1:0] inValid,
  input logic [routerPkg::numPorts-1:0] inReady,
  input routerPkg::outFlit_t outFlit,
  input logic outValid,
  input logic outReady,
  output int errorCount,
  output int pendingFlits,
  output int deliveredFlits
);

  routerPkg::flit_t expQ [routerPkg::numPorts][$]; // Mirrors each input FIFO
  logic [routerPkg::lengthWidth-1:0] lastLen [routerPkg::numPorts];
  logic [routerPkg::numPorts-1:0] busyPrev;
  logic rstPrev = 1'b0;
  logic stalled;
  routerPkg::outFlit_t stalledFlit;
  logic haveLast;
  int lastSrc;
  int gapCycles;
  int holdCycles;
  int errors = 0;
  int pending = 0;
  int delivered = 0;

  assign errorCount = errors;
  assign pendingFlits = pending;
  assign deliveredFlits = delivered;

  task automatic flagError(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  always @(posedge clk)
  begin
    logic [routerPkg::numPorts-1:0] busyNow;
    logic [routerPkg::numPorts-1:0] others;
    int src;
    int k;
    if (rst)
    begin
      if (rstPrev && outValid !== 1'b0)
        flagError("outValid is not 0 during reset");
      for (int p = 0; p < routerPkg::numPorts; p++)
      begin
        expQ[p].delete();
        lastLen[p] = '0;
      end
      stalled = 1'b0;
      haveLast = 1'b0;
      holdCycles = 0;
      busyPrev = '0;
      pending = 0;
    end
    else
    begin
      src = int'(outFlit.srcPort);
      for (int p = 0; p < routerPkg::numPorts; p++)
      begin
        busyNow[p] = (expQ[p].size() != 0);
        // A full FIFO only takes a flit in the cycle its head leaves
        if (expQ[p].size() < routerPkg::fifoDepth && inReady[p] !== 1'b1)
          flagError($sformatf("inReady[%0d] is low with %0d flits queued", p, expQ[p].size()));
        else if (expQ[p].size() == routerPkg::fifoDepth && inReady[p] !== 1'b0
                 && !(outValid && outReady && src == p))
          flagError($sformatf("inReady[%0d] is high while its FIFO is full", p));
      end
      if (outValid === 1'b1 && busyNow == '0)
        flagError("outValid is high with every FIFO empty");
      if (outValid === 1'b1 && src >= routerPkg::numPorts)
        flagError($sformatf("srcPort %0d is not a valid port", src));
      else if (outValid === 1'b1)
      begin
        if (stalled && stalledFlit.srcPort == outFlit.srcPort && outFlit != stalledFlit)
          flagError($sformatf("port %0d changed its flit while stalled", src));
        // The handover was decided one cycle earlier, so ports skipped then must be empty
        if (haveLast && src != lastSrc && gapCycles <= 1)
        begin
          k = (lastSrc + 1) % routerPkg::numPorts;
          while (k != src)
          begin
            if (busyPrev[k])
              flagError($sformatf("grant moved from port %0d to %0d past waiting port %0d",
                                  lastSrc, src, k));
            k = (k + 1) % routerPkg::numPorts;
          end
        end
        others = busyNow;
        others[src] = 1'b0;
        if (others != '0)
        begin
          holdCycles = (holdCycles > 0 && src == lastSrc) ? holdCycles + 1 : 1;
          if (holdCycles == int'(lastLen[src]) + 2)
            flagError($sformatf("port %0d held the link over %0d cycles while others waited",
                                src, int'(lastLen[src]) + 1));
        end
        else
          holdCycles = 0;
        if (outReady === 1'b1)
        begin
          if (expQ[src].size() == 0)
            flagError($sformatf("port %0d delivered a flit that was never sent", src));
          else
          begin
            if (outFlit.flit != expQ[src][0])
              flagError($sformatf("port %0d delivered %h, expected %h",
                                  src, outFlit.flit, expQ[src][0]));
            expQ[src].delete(0);
            delivered++;
          end
        end
        lastSrc = src;
        haveLast = 1'b1;
        gapCycles = 0;
      end
      else
      begin
        gapCycles++;
        holdCycles = 0;
      end
      stalled = (outValid === 1'b1 && outReady !== 1'b1);
      stalledFlit = outFlit;
      pending = 0;
      for (int p = 0; p < routerPkg::numPorts; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          expQ[p].push_back(inFlit[p]);
          if (inFlit[p].flitType == routerPkg::flitHeader)
            lastLen[p] = inFlit[p].length; // Same edge the timer loads its limit
        end
        pending += expQ[p].size();
      end
      busyPrev = busyNow;
    end
    rstPrev = rst;
  end

endmodule

// ==== design/outputPort.sv ====
`timescale 1ns/10ps

module outputPort (
  input logic clk,
  input logic rst,
  input routerPkg::flit_t inFlit [routerPkg::numPorts],
  input logic [routerPkg::numPorts-1:0] inValid,
  output logic [routerPkg::numPorts-1:0] inReady,
  output routerPkg::outFlit_t outFlit,
  output logic outValid,
  input logic outReady
);

  routerPkg::flit_t headFlit [routerPkg::numPorts];
  logic [routerPkg::numPorts-1:0] notEmpty;
  logic [routerPkg::numPorts-1:0] pop;
  logic [routerPkg::numPorts-1:0] headerPush;
  logic [routerPkg::numPorts-1:0] timesUp;
  logic [routerPkg::numPorts-1:0] runTimer;
  routerPkg::portSel_t grant;

  for (genvar p = 0; p < routerPkg::numPorts; p++)
  begin : g_port
    flitFifo i_flitFifo (
      .clk(clk),
      .rst(rst),
      .inFlit(inFlit[p]),
      .inValid(inValid[p]),
      .inReady(inReady[p]),
      .headFlit(headFlit[p]),
      .notEmpty(notEmpty[p]),
      .pop(pop[p])
    );

    // Timer limit follows headers as they enter the FIFO
    assign headerPush[p] = inValid[p] && inReady[p]
                           && (inFlit[p].flitType == routerPkg::flitHeader);

    grantTimer i_grantTimer (
      .clk(clk),
      .rst(rst),
      .headerPush(headerPush[p]),
      .headerLength(inFlit[p].length),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  outputArbiter i_outputArbiter (
    .clk(clk),
    .rst(rst),
    .request(notEmpty),
    .timesUp(timesUp),
    .runTimer(runTimer),
    .grant(grant)
  );

  outputMux i_outputMux (
    .grant(grant),
    .headFlit(headFlit),
    .notEmpty(notEmpty),
    .outReady(outReady),
    .outFlit(outFlit),
    .outValid(outValid),
    .pop(pop)
  );

endmodule

// ==== design/outputMux.sv ====
`timescale 1ns/10ps

module outputMux (
  input routerPkg::portSel_t grant,
  input routerPkg::flit_t headFlit [routerPkg::numPorts],
  input logic [routerPkg::numPorts-1:0] notEmpty,
  input logic outReady,
  output routerPkg::outFlit_t outFlit,
  output logic outValid,
  output logic [routerPkg::numPorts-1:0] pop
);

  routerPkg::portIdx_t selPort;
  logic selected;

  always_comb
  begin
    selPort = '0;
    selected = 1'b0;
    for (int i = 0; i < routerPkg::numPorts; i++)
    begin
      if (grant[i + 1])
      begin
        selPort = routerPkg::portIdx_t'(i);
        selected = 1'b1;
      end
    end
  end

  assign outFlit = '{flit: headFlit[selPort], srcPort: selPort};
  assign outValid = selected && notEmpty[selPort]; // Idle grant offers nothing

  always_comb
  begin
    pop = '0;
    if (outValid && outReady)
    begin
      pop[selPort] = 1'b1;
    end
  end

endmodule

// ==== design/outputArbiter.sv ====
`timescale 1ns/10ps

module outputArbiter (
  input logic clk,
  input logic rst,
  input logic [routerPkg::numPorts-1:0] request,
  input logic [routerPkg::numPorts-1:0] timesUp,
  output logic [routerPkg::numPorts-1:0] runTimer,
  output routerPkg::portSel_t grant
);

  routerPkg::portSel_t nextGrant;

  // Picks the first requesting port at or after start, wrapping round
  function automatic routerPkg::portSel_t searchFrom(
    input logic [routerPkg::numPorts-1:0] req,
    input int start
  );
    routerPkg::portSel_t sel;
    int idx;
    sel = routerPkg::selIdle;
    for (int k = routerPkg::numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % routerPkg::numPorts;
      if (req[idx])
      begin
        sel = '0;
        sel[idx + 1] = 1'b1; // Nearer ports overwrite farther ones
      end
    end
    return sel;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= routerPkg::selIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  always_comb
  begin
    nextGrant = searchFrom(request, 0); // From idle Local is looked at first
    runTimer = '0;
    for (int i = 0; i < routerPkg::numPorts; i++)
    begin
      if (grant[i + 1])
      begin
        if (request[i] && !timesUp[i])
        begin
          nextGrant = grant;
          runTimer[i] = 1'b1;
        end
        else
        begin
          // The port that just finished comes last in the search
          nextGrant = searchFrom(request, i + 1);
        end
      end
    end
    if (!$onehot(grant))
    begin
      nextGrant = routerPkg::selIdle; // Recover from a corrupted state
      runTimer = '0;
    end
  end

endmodule

// ==== design/grantTimer.sv ====
`timescale 1ns/10ps

module grantTimer (
  input logic clk,
  input logic rst,
  input logic headerPush,
  input logic [routerPkg::lengthWidth-1:0] headerLength,
  input logic runTimer,
  output logic timesUp
);

  logic [routerPkg::lengthWidth-1:0] limit;
  logic [routerPkg::lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headerPush)
      begin
        limit <= headerLength; // Latest header sets the timeout for this port
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // With a limit of L the port keeps the link for L + 1 cycles
  assign timesUp = (count == limit);

endmodule

// ==== design/flitFifo.sv ====
`timescale 1ns/10ps

module flitFifo (
  input logic clk,
  input logic rst,
  input routerPkg::flit_t inFlit,
  input logic inValid,
  output logic inReady,
  output routerPkg::flit_t headFlit,
  output logic notEmpty,
  input logic pop
);

  routerPkg::flit_t mem [routerPkg::fifoDepth];
  logic [routerPkg::ptrWidth-1:0] wrPtr;
  logic [routerPkg::ptrWidth-1:0] rdPtr;
  logic [routerPkg::countWidth-1:0] count;
  logic full;
  logic push;
  logic doPop;

  assign full = (count == routerPkg::countWidth'(routerPkg::fifoDepth));
  assign notEmpty = (count != '0);
  assign doPop = pop && notEmpty;
  assign inReady = !full || doPop; // A full FIFO still takes a flit when its head leaves
  assign push = inValid && inReady;
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= wrPtr + 1'b1; // Depth is a power of two so the pointer wraps by itself
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, doPop})
        2'b10:
        begin
          count <= count + 1'b1;
        end
        2'b01:
        begin
          count <= count - 1'b1;
        end
        default:
        begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// ==== design/routerPkg.sv ====
package routerPkg;

  localparam int numPorts = 5;
  localparam int lengthWidth = 12;
  localparam int dataWidth = 16;
  localparam int fifoDepth = 4;
  localparam int portIdxWidth = 3;
  localparam int ptrWidth = $clog2(fifoDepth);
  localparam int countWidth = $clog2(fifoDepth + 1);

  // Port index as carried in srcPort, 0 is Local up to 4 for South
  typedef logic [portIdxWidth-1:0] portIdx_t;

  // One-hot grant state
  typedef logic [numPorts:0] portSel_t; // Bit 0 idle, bits 1 to 5 Local to South

  localparam portSel_t selIdle = portSel_t'(1);

  typedef enum logic [2:0] {
    flitHeader = 3'b001,
    flitBody   = 3'b010,
    flitTail   = 3'b100
  } flitType_t;

  typedef struct packed {
    flitType_t flitType;
    logic [lengthWidth-1:0] length; // Only meaningful in a header flit
    logic [dataWidth-1:0] data;
  } flit_t;

  typedef struct packed {
    flit_t flit;
    portIdx_t srcPort;
  } outFlit_t;

endpackage
